// ==== rtl/ghrd_pkg.sv ====
package ghrd_pkg;

  // ====================
  // widths
  // ====================
  localparam int axil_addr_w  = 8;    // byte offsets into the csr block
  localparam int axil_data_w  = 32;
  localparam int num_buttons  = 4;    // KEY[3:0]
  localparam int num_switches = 10;   // SW[9:0]
  localparam int num_leds     = 9;    // software leds on LEDR[9:1]
  localparam int stm_event_w  = 28;   // hps trace event word

  // ====================
  // timing
  // ====================
  localparam int debounce_cycles    = 50000;      // 1 ms at 50 MHz
  localparam int debounce_cnt_w     = 16;         // holds debounce_cycles
  localparam int heartbeat_cycles   = 25000000;   // 0.5 s half period
  localparam int cold_pulse_cycles  = 6;
  localparam int warm_pulse_cycles  = 2;
  localparam int debug_pulse_cycles = 32;

  localparam logic [axil_data_w-1:0] ghrd_id_value = 32'h4748_5244;  // ascii "GHRD"

  // register offsets
  typedef enum logic [axil_addr_w-1:0] {
    csr_id        = 8'h00,   // ro
    csr_buttons   = 8'h04,   // ro, debounced
    csr_switches  = 8'h08,   // ro
    csr_leds      = 8'h0C,   // rw
    csr_reset_req = 8'h10    // wo, {debug, warm, cold}
  } csr_addr_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axil_resp_e;

  typedef enum logic {
    pulse_idle,
    pulse_active
  } pulse_state_e;

  typedef enum logic {
    deb_stable,
    deb_settling
  } deb_state_e;

endpackage

// ==== rtl/panel_if.sv ====
interface panel_if;
  import ghrd_pkg::*;

  logic [num_buttons-1:0]  buttons;     // debounced, 1 = pressed
  logic [num_switches-1:0] switches;    // raw slide switch levels
  logic [num_leds-1:0]     leds;        // software led register
  logic [2:0]              reset_req;   // one-cycle strobes {debug, warm, cold}

  // register block side
  modport csr (
    input  buttons,
    input  switches,
    output leds,
    output reset_req
  );

  // board panel side
  modport panel (
    output buttons,
    output switches,
    input  leds,
    input  reset_req
  );

endinterface

// ==== rtl/button_debouncer.sv ====
module button_debouncer #(
  parameter int limit = ghrd_pkg::debounce_cycles
) (
  input  logic                             fpga_clk_50,
  input  logic                             hps_fpga_reset_n,
  input  logic [ghrd_pkg::num_buttons-1:0] key,       // active low pins
  output logic [ghrd_pkg::num_buttons-1:0] pressed    // clean, active high
);
  import ghrd_pkg::*;

  logic [num_buttons-1:0]    sync_meta;   // first sync stage
  logic [num_buttons-1:0]    sync_out;    // second sync stage
  logic [num_buttons-1:0]    last;        // previous synced sample
  logic [debounce_cnt_w-1:0] cnt;         // shared stable-time counter
  deb_state_e                state;

  // two-flop synchronizer, polarity flipped on the way in
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      sync_meta <= '0;            // released key reads as not pressed
      sync_out  <= '0;
    end
    else
    begin
      sync_meta <= ~key;
      sync_out  <= sync_meta;
    end
  end

  // one window for all buttons, any edge restarts it
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      last    <= '0;
      cnt     <= '0;
      state   <= deb_stable;
      pressed <= '0;
    end
    else
    begin
      last <= sync_out;
      if (sync_out != last)
      begin
        cnt   <= '0;              // bounce seen, start over
        state <= deb_settling;
      end
      else if (state == deb_settling)
      begin
        if (cnt == debounce_cnt_w'(limit - 1))
        begin
          pressed <= last;        // input held long enough
          state   <= deb_stable;
        end
        else
          cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/reset_pulse_stretcher.sv ====
module reset_pulse_stretcher #(
  parameter int pulse_len = ghrd_pkg::cold_pulse_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,        // strobe from the register block
  output logic reset_req_n     // low for pulse_len cycles
);
  import ghrd_pkg::*;

  pulse_state_e                  state;
  logic                          req_q;       // request one cycle back
  logic [$clog2(pulse_len):0]    remaining;   // cycles left after this one
  logic                          req_rise;

  assign req_rise = request && !req_q;         // rising edge only

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state     <= pulse_idle;
      req_q     <= 1'b0;
      remaining <= '0;
    end
    else
    begin
      req_q <= request;
      case (state)
        pulse_idle:
        begin
          if (req_rise)
          begin
            state     <= pulse_active;     // output drops next cycle
            remaining <= ($clog2(pulse_len) + 1)'(pulse_len - 1);
          end
        end
        pulse_active:
        begin
          // new requests fall through here and are dropped
          if (remaining == '0)
            state <= pulse_idle;
          else
            remaining <= remaining - 1'b1;
        end
        default:
          state <= pulse_idle;
      endcase
    end
  end

  assign reset_req_n = (state != pulse_active);   // straight from the state flop

endmodule

// ==== rtl/heartbeat_blinker.sv ====
module heartbeat_blinker #(
  parameter int half_period = ghrd_pkg::heartbeat_cycles
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic led               // LEDR[0]
);

  logic [$clog2(half_period)-1:0] cnt;   // wraps every half_period clocks

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      cnt <= '0;
      led <= 1'b0;
    end
    else if (cnt == ($clog2(half_period))'(half_period - 1))
    begin
      cnt <= '0;
      led <= ~led;               // toggle on wrap
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

// ==== rtl/ghrd_csr.sv ====
module ghrd_csr (
  input  logic                                fpga_clk_50,
  input  logic                                hps_fpga_reset_n,
  // write address and data
  input  logic [ghrd_pkg::axil_addr_w-1:0]    awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [ghrd_pkg::axil_data_w-1:0]    wdata,
  input  logic [ghrd_pkg::axil_data_w/8-1:0]  wstrb,     // full word writes only
  input  logic                                wvalid,
  output logic                                wready,
  // write response
  output ghrd_pkg::axil_resp_e                bresp,
  output logic                                bvalid,
  input  logic                                bready,
  // read address and data
  input  logic [ghrd_pkg::axil_addr_w-1:0]    araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [ghrd_pkg::axil_data_w-1:0]    rdata,
  output ghrd_pkg::axil_resp_e                rresp,
  output logic                                rvalid,
  input  logic                                rready,
  panel_if.csr                                panel
);
  import ghrd_pkg::*;

  logic [num_leds-1:0]    led_q;        // software led register
  logic [2:0]             rst_strobe;   // reset request strobes
  logic                   wr_fire;      // aw and w handshake this cycle
  logic                   rd_fire;      // ar handshake this cycle
  logic                   led_sel;
  logic                   rst_sel;
  logic [axil_data_w-1:0] rd_word;
  axil_resp_e             rd_resp;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  // ====================
  // address decode
  // ====================
  always_comb
  begin
    led_sel = 1'b0;
    rst_sel = 1'b0;
    case (csr_addr_e'(awaddr))
      csr_leds:      led_sel = 1'b1;
      csr_reset_req: rst_sel = 1'b1;
      default:       ;                  // read only or unmapped gives slverr
    endcase
  end

  always_comb
  begin
    rd_word = '0;
    rd_resp = resp_okay;
    case (csr_addr_e'(araddr))
      csr_id:        rd_word = ghrd_id_value;
      csr_buttons:   rd_word = axil_data_w'(panel.buttons);
      csr_switches:  rd_word = axil_data_w'(panel.switches);
      csr_leds:      rd_word = axil_data_w'(led_q);
      csr_reset_req: rd_word = '0;      // write only register reads zero
      default:       rd_resp = resp_slverr;
    endcase
  end

  // ====================
  // handshake + regs
  // ====================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      led_q      <= '0;
      rst_strobe <= '0;
    end
    else
    begin
      // aw and w taken together with a single-cycle ready
      awready    <= awvalid && wvalid && !bvalid && !awready;
      wready     <= awvalid && wvalid && !bvalid && !awready;
      arready    <= arvalid && !rvalid && !arready;    // held rvalid blocks
      rst_strobe <= '0;                                 // strobes last one cycle

      if (wr_fire)
      begin
        bvalid <= 1'b1;
        if (led_sel)
          led_q <= wdata[num_leds-1:0];
        if (rst_sel)
          rst_strobe <= wdata[2:0];                     // bit per requester
      end
      else if (bvalid && bready)
        bvalid <= 1'b0;

      if (rd_fire)
        rvalid <= 1'b1;
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  // response payload latched on each handshake
  always_ff @(posedge fpga_clk_50)
  begin
    if (wr_fire)
    begin
      if (led_sel || rst_sel)
        bresp <= resp_okay;
      else
        bresp <= resp_slverr;            // ro register or hole
    end
    if (rd_fire)
    begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  assign panel.leds      = led_q;
  assign panel.reset_req = rst_strobe;

endmodule

// ==== rtl/ghrd_ctrl_top.sv ====
module ghrd_ctrl_top #(
  parameter int debounce_limit    = ghrd_pkg::debounce_cycles,
  parameter int blink_half_period = ghrd_pkg::heartbeat_cycles
) (
  input  logic                                fpga_clk_50,
  input  logic                                hps_fpga_reset_n,
  // board panel
  input  logic [ghrd_pkg::num_buttons-1:0]    key,
  input  logic [ghrd_pkg::num_switches-1:0]   sw,
  output logic [ghrd_pkg::num_leds:0]         ledr,
  output logic [ghrd_pkg::stm_event_w-1:0]    stm_hw_events,
  output logic                                hps_cold_reset_req_n,
  output logic                                hps_warm_reset_req_n,
  output logic                                hps_debug_reset_req_n,
  // axi4-lite slave
  input  logic [ghrd_pkg::axil_addr_w-1:0]    awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [ghrd_pkg::axil_data_w-1:0]    wdata,
  input  logic [ghrd_pkg::axil_data_w/8-1:0]  wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [ghrd_pkg::axil_addr_w-1:0]    araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [ghrd_pkg::axil_data_w-1:0]    rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready
);
  import ghrd_pkg::*;

  logic [num_buttons-1:0] buttons_clean;   // debouncer out
  logic                   heartbeat;

  panel_if pnl ();

  // ====================
  // panel wiring
  // ====================
  assign pnl.switches = sw;
  assign pnl.buttons  = buttons_clean;
  assign ledr         = {pnl.leds, heartbeat};   // heartbeat on LEDR[0]

  // trace word, zero padded at the top
  assign stm_hw_events = {{(stm_event_w - num_switches - num_leds - num_buttons){1'b0}},
                          sw, pnl.leds, buttons_clean};

  ghrd_csr i_csr (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .awaddr           (awaddr),
    .awvalid          (awvalid),
    .awready          (awready),
    .wdata            (wdata),
    .wstrb            (wstrb),
    .wvalid           (wvalid),
    .wready           (wready),
    .bresp            (bresp),
    .bvalid           (bvalid),
    .bready           (bready),
    .araddr           (araddr),
    .arvalid          (arvalid),
    .arready          (arready),
    .rdata            (rdata),
    .rresp            (rresp),
    .rvalid           (rvalid),
    .rready           (rready),
    .panel            (pnl)
  );

  button_debouncer #(.limit(debounce_limit)) i_debouncer (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .pressed          (buttons_clean)
  );

  // reset request pulses, bit 0 cold / 1 warm / 2 debug
  reset_pulse_stretcher #(.pulse_len(cold_pulse_cycles)) i_cold_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (pnl.reset_req[0]),
    .reset_req_n      (hps_cold_reset_req_n)
  );

  reset_pulse_stretcher #(.pulse_len(warm_pulse_cycles)) i_warm_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (pnl.reset_req[1]),
    .reset_req_n      (hps_warm_reset_req_n)
  );

  reset_pulse_stretcher #(.pulse_len(debug_pulse_cycles)) i_debug_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (pnl.reset_req[2]),
    .reset_req_n      (hps_debug_reset_req_n)
  );

  heartbeat_blinker #(.half_period(blink_half_period)) i_heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .led              (heartbeat)
  );

endmodule

// ==== verification/ghrd_ctrl_tasks.svh ====
`ifndef GHRD_CTRL_TASKS_SVH
`define GHRD_CTRL_TASKS_SVH

// ====================
// compare + report
// ====================
task automatic report_failure(input string what);
  fail_count++;
  $display("ERROR at %0t: %s", $time, what);
endtask

task automatic check_word(input string name, input logic [axil_data_w-1:0] got,
                          input logic [axil_data_w-1:0] exp);
  if (got !== exp)
  begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
  if (got !== exp)
  begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %s (%b) expected %s (%b)",
             $time, name, got.name(), got, exp.name(), exp);
  end
endtask

task automatic check_vec(input string name, input logic [stm_event_w-1:0] got,
                         input logic [stm_event_w-1:0] exp);
  if (got !== exp)
  begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_cycles(input string name, input int got, input int exp);
  if (got != exp)
  begin
    mismatch_count++;
    $display("MISMATCH at %0t: %s got %0d cycles expected %0d", $time, name, got, exp);
  end
endtask

// ====================
// axi4-lite master
// ====================
// hold is the number of cycles bready stays low once bvalid is up
task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                          input logic [axil_data_w-1:0] data,
                          input int hold, output axil_resp_e resp);
  int   waited;
  logic seen;
  resp   = resp_slverr;
  waited = 0;
  @(posedge fpga_clk_50);
  awaddr  <= addr;
  awvalid <= 1'b1;
  wdata   <= data;
  wstrb   <= '1;
  wvalid  <= 1'b1;
  bready  <= (hold == 0);
  @(negedge fpga_clk_50);
  while (!(awready && wready) && waited < bus_wait_max)
  begin
    @(negedge fpga_clk_50);
    waited++;
  end
  seen = awready && wready;
  @(posedge fpga_clk_50);            // handshake edge
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  if (!seen)
  begin
    bready <= 1'b0;
    report_failure($sformatf("no awready/wready for write to offset %h", addr));
    return;
  end
  @(negedge fpga_clk_50);
  if (!bvalid)
  begin
    report_failure($sformatf("no bvalid after write to offset %h", addr));
    return;
  end
  resp = axil_resp_e'(bresp);
  repeat (hold)
  begin
    @(negedge fpga_clk_50);
    if (!bvalid)
      report_failure("bvalid dropped while bready was low");
  end
  if (hold > 0)
  begin
    @(posedge fpga_clk_50);
    bready <= 1'b1;
  end
  @(posedge fpga_clk_50);            // response taken here
  bready <= 1'b0;
  @(negedge fpga_clk_50);
  if (bvalid)
    report_failure("bvalid still high after the response was taken");
endtask

// hold is the number of cycles rready stays low once rvalid is up
task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int hold,
                         output logic [axil_data_w-1:0] data, output axil_resp_e resp);
  int   waited;
  logic seen;
  data   = 'x;
  resp   = resp_slverr;
  waited = 0;
  @(posedge fpga_clk_50);
  araddr  <= addr;
  arvalid <= 1'b1;
  rready  <= (hold == 0);
  @(negedge fpga_clk_50);
  while (!arready && waited < bus_wait_max)
  begin
    @(negedge fpga_clk_50);
    waited++;
  end
  seen = arready;
  @(posedge fpga_clk_50);            // handshake edge
  arvalid <= 1'b0;
  if (!seen)
  begin
    rready <= 1'b0;
    report_failure($sformatf("no arready for read of offset %h", addr));
    return;
  end
  @(negedge fpga_clk_50);
  if (!rvalid)
  begin
    report_failure($sformatf("no rvalid after read of offset %h", addr));
    return;
  end
  data = rdata;
  resp = axil_resp_e'(rresp);
  repeat (hold)
  begin
    @(negedge fpga_clk_50);
    if (!rvalid || rdata !== data)
      report_failure("read response changed while rready was low");
  end
  if (hold > 0)
  begin
    @(posedge fpga_clk_50);
    rready <= 1'b1;
  end
  @(posedge fpga_clk_50);
  rready <= 1'b0;
  @(negedge fpga_clk_50);
  if (rvalid)
    report_failure("rvalid still high after the data was taken");
endtask

// ====================
// panel helpers
// ====================
function automatic logic reset_pin(input int which);
  case (which)
    0:       return hps_cold_reset_req_n;
    1:       return hps_warm_reset_req_n;
    default: return hps_debug_reset_req_n;
  endcase
endfunction

// low time of one reset request output
task automatic measure_pulse(input int which, output int len);
  int waited;
  len    = 0;                         // stays 0 if the pin never drops
  waited = 0;
  @(negedge fpga_clk_50);
  while (reset_pin(which) && waited < 4 * bus_wait_max)
  begin
    @(negedge fpga_clk_50);
    waited++;
  end
  while (!reset_pin(which) && len < 4 * debug_pulse_cycles)
  begin
    len++;
    @(negedge fpga_clk_50);
  end
endtask

// polls the buttons field of the trace word every cycle
task automatic wait_buttons(input logic [num_buttons-1:0] exp, input string what);
  int waited;
  waited = 0;
  do
  begin
    @(negedge fpga_clk_50);
    waited++;
  end
  while (stm_hw_events[num_buttons-1:0] !== exp && waited < deb_limit + 4);
  if (stm_hw_events[num_buttons-1:0] !== exp)
    report_failure($sformatf("%s not seen within %0d cycles", what, deb_limit + 4));
endtask

// ====================
// directed tests
// ====================
task automatic test_reset_id();
  logic [axil_data_w-1:0] data;
  axil_resp_e             resp;
  @(negedge fpga_clk_50);
  check_vec("reset_req_n {debug,warm,cold}", stm_event_w'({hps_debug_reset_req_n,
            hps_warm_reset_req_n, hps_cold_reset_req_n}), stm_event_w'(3'b111));
  check_vec("ledr", stm_event_w'(ledr), '0);
  check_vec("{bvalid,rvalid}", stm_event_w'({bvalid, rvalid}), '0);
  check_vec("{awready,wready,arready}", stm_event_w'({awready, wready, arready}), '0);
  check_vec("debounced buttons", stm_event_w'(stm_hw_events[num_buttons-1:0]), '0);
  axil_read(csr_id, 0, data, resp);
  check_word("csr_id rdata", data, ghrd_id_value);
  check_resp("csr_id rresp", resp, resp_okay);
endtask

task automatic test_switches_leds();
  logic [num_switches-1:0] sw_val;
  logic [axil_data_w-1:0]  led_word;
  logic [num_leds-1:0]     led_val;
  logic [axil_data_w-1:0]  data;
  axil_resp_e              resp;
  int                      hold;
  int                      i;
  for (i = 0; i < num_loops; i++)
  begin
    sw_val   = num_switches'($random(seed));
    led_word = $random(seed);
    led_val  = led_word[num_leds-1:0];   // register keeps the low bits
    hold     = $unsigned($random(seed)) % 8;
    @(posedge fpga_clk_50);
    sw <= sw_val;
    axil_write(csr_leds, led_word, hold, resp);
    check_resp("csr_leds bresp", resp, resp_okay);
    axil_read(csr_switches, hold, data, resp);
    check_word("csr_switches rdata", data, axil_data_w'(sw_val));
    check_resp("csr_switches rresp", resp, resp_okay);
    hold = $unsigned($random(seed)) % 8;
    axil_read(csr_leds, hold, data, resp);
    check_word("csr_leds rdata", data, axil_data_w'(led_val));
    check_resp("csr_leds rresp", resp, resp_okay);
    @(negedge fpga_clk_50);
    check_vec("ledr[9:1]", stm_event_w'(ledr[num_leds:1]), stm_event_w'(led_val));
    check_vec("stm_hw_events", stm_hw_events,
              stm_event_w'({sw_val, led_val, {num_buttons{1'b0}}}));   // zero padded on top
  end
endtask

task automatic test_debounce();
  logic [axil_data_w-1:0] data;
  axil_resp_e             resp;
  int                     i;
  @(posedge fpga_clk_50);
  key <= 4'b1101;                        // 10-cycle glitch on key[1]
  repeat (10) @(posedge fpga_clk_50);
  key <= 4'b1111;
  for (i = 0; i < 2 * deb_limit + 10; i++)
  begin
    @(negedge fpga_clk_50);
    if (stm_hw_events[num_buttons-1:0] !== '0)
    begin
      report_failure("10-cycle glitch on key[1] reached the buttons register");
      break;
    end
  end
  axil_read(csr_buttons, 0, data, resp);
  check_word("csr_buttons after glitch", data, '0);

  @(posedge fpga_clk_50);
  key <= 4'b1011;                        // hold key[2]
  wait_buttons(4'b0100, "key[2] press");
  axil_read(csr_buttons, 0, data, resp);
  check_word("csr_buttons while key[2] held", data, 32'h0000_0004);
  check_resp("csr_buttons rresp", resp, resp_okay);

  @(posedge fpga_clk_50);
  key <= 4'b1111;
  wait_buttons(4'b0000, "key[2] release");
  axil_read(csr_buttons, 0, data, resp);
  check_word("csr_buttons after release", data, '0);
endtask

task automatic test_reset_pulses();
  logic [axil_data_w-1:0] data;
  axil_resp_e             resp;
  int                     len;
  int                     lens [3];
  string                  names [3];
  int                     i;
  lens[0]  = cold_pulse_cycles;
  lens[1]  = warm_pulse_cycles;
  lens[2]  = debug_pulse_cycles;
  names[0] = "hps_cold_reset_req_n pulse";
  names[1] = "hps_warm_reset_req_n pulse";
  names[2] = "hps_debug_reset_req_n pulse";
  for (i = 0; i < 3; i++)
  begin
    fork
      measure_pulse(i, len);
      axil_write(csr_reset_req, axil_data_w'(1) << i, 0, resp);
    join
    check_cycles(names[i], len, lens[i]);
    check_resp("csr_reset_req bresp", resp, resp_okay);
  end

  // debug again with a second request inside the pulse
  fork
    measure_pulse(2, len);
    begin
      axil_write(csr_reset_req, 32'h0000_0004, 0, resp);
      repeat (5) @(posedge fpga_clk_50);
      axil_write(csr_reset_req, 32'h0000_0004, 0, resp);
    end
  join
  check_cycles("debug pulse with a second request", len, debug_pulse_cycles);
  check_resp("second debug request bresp", resp, resp_okay);
  for (i = 0; i < 2 * debug_pulse_cycles; i++)
  begin
    @(negedge fpga_clk_50);
    if (!hps_debug_reset_req_n)
    begin
      report_failure("second debug request started another pulse");
      break;
    end
  end

  axil_read(csr_reset_req, 0, data, resp);
  check_word("csr_reset_req rdata", data, '0);
  check_resp("csr_reset_req rresp", resp, resp_okay);
endtask

task automatic test_errors();
  logic [axil_data_w-1:0] data;
  logic [axil_data_w-1:0] id_word;
  logic [num_leds-1:0]    led_val;
  axil_resp_e             resp;
  led_val = 9'h155;
  axil_read(8'h14, 0, data, resp);       // first hole past the map
  check_resp("unmapped 0x14 rresp", resp, resp_slverr);
  check_word("unmapped 0x14 rdata", data, '0);
  axil_read(8'hFC, 0, data, resp);
  check_resp("unmapped 0xFC rresp", resp, resp_slverr);
  check_word("unmapped 0xFC rdata", data, '0);
  axil_write(csr_leds, axil_data_w'(led_val), 0, resp);
  check_resp("csr_leds bresp", resp, resp_okay);
  id_word                = $random(seed);
  id_word[num_leds-1:0]  = ~led_val;     // differs from the led register
  axil_write(csr_id, id_word, 0, resp);
  check_resp("csr_id write bresp", resp, resp_slverr);
  axil_read(csr_id, 0, data, resp);
  check_word("csr_id after write", data, ghrd_id_value);
  check_resp("csr_id rresp", resp, resp_okay);
  axil_read(csr_leds, 0, data, resp);
  check_word("csr_leds after csr_id write", data, axil_data_w'(led_val));
endtask

task automatic test_heartbeat();
  logic last_led;
  int   count;
  int   k;
  @(negedge fpga_clk_50);
  last_led = ledr[0];
  count    = 0;
  while (ledr[0] === last_led && count < 2 * blink_half)   // line up on a toggle
  begin
    @(negedge fpga_clk_50);
    count++;
  end
  for (k = 0; k < 2; k++)
  begin
    last_led = ledr[0];
    count    = 0;
    do
    begin
      @(negedge fpga_clk_50);
      count++;
    end
    while (ledr[0] === last_led && count < 2 * blink_half);
    check_cycles("ledr[0] toggle interval", count, blink_half);
  end
endtask

`endif

// ==== verification/ghrd_ctrl_tb.sv ====
module ghrd_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ghrd_pkg::*;

  // ====================
  // test sizing
  // ====================
  localparam int clk_half     = 4;      // 8 ns period
  localparam int deb_limit    = 20;     // short debounce window
  localparam int blink_half   = 100;    // short heartbeat half period
  localparam int reset_cycles = 16;
  localparam int bus_wait_max = 16;     // ready/valid wait bound per channel
  localparam int bus_op_max   = 2 * bus_wait_max + 12;   // one transfer incl. hold
  localparam int num_loops    = 6;      // random rounds, switch/led test

  // cycle budget of each directed test
  localparam int t_reset_id  = 2 * bus_op_max;
  localparam int t_sw_leds   = num_loops * 3 * bus_op_max;
  localparam int t_debounce  = 3 * (2 * deb_limit + 20) + 4 * bus_op_max;
  localparam int t_pulses    = 5 * (2 * debug_pulse_cycles + 50) + 8 * bus_op_max;
  localparam int t_errors    = 5 * bus_op_max;
  localparam int t_heartbeat = 4 * blink_half + 10;
  localparam int watchdog_cycles = reset_cycles + t_reset_id + t_sw_leds + t_debounce
                                   + t_pulses + t_errors + t_heartbeat + 500;   // + margin

  logic                     fpga_clk_50;
  logic                     hps_fpga_reset_n;
  logic [num_buttons-1:0]   key;
  logic [num_switches-1:0]  sw;
  logic [num_leds:0]        ledr;
  logic [stm_event_w-1:0]   stm_hw_events;
  logic                     hps_cold_reset_req_n;
  logic                     hps_warm_reset_req_n;
  logic                     hps_debug_reset_req_n;
  logic [axil_addr_w-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [axil_data_w-1:0]   wdata;
  logic [axil_data_w/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [axil_addr_w-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [axil_data_w-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  int seed;              // $random state
  int mismatch_count;    // wrong values
  int fail_count;        // timeouts, protocol slips

  ghrd_ctrl_top #(
    .debounce_limit    (deb_limit),
    .blink_half_period (blink_half)
  ) i_dut (.*);

  always #(clk_half) fpga_clk_50 = ~fpga_clk_50;

  `include "ghrd_ctrl_tasks.svh"

  // ====================
  // test sequence
  // ====================
  initial
  begin
    seed             = 32'h5781_7a5c;
    mismatch_count   = 0;
    fail_count       = 0;
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;   // reset from time zero
    key              = '1;     // all buttons released
    sw               = '0;
    awaddr           = '0;
    awvalid          = 1'b0;
    wdata            = '0;
    wstrb            = '0;
    wvalid           = 1'b0;
    bready           = 1'b0;
    araddr           = '0;
    arvalid          = 1'b0;
    rready           = 1'b0;
    repeat (reset_cycles) @(posedge fpga_clk_50);
    hps_fpga_reset_n <= 1'b1;

    test_reset_id();
    test_switches_leds();
    test_debounce();
    test_reset_pulses();
    test_errors();
    test_heartbeat();

    $display("summary: %0d mismatches, %0d other errors", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // hang guard, sized from the test budgets above
  initial
  begin
    repeat (watchdog_cycles) @(posedge fpga_clk_50);
    $display("watchdog expired after %0d cycles, test sequence never finished",
             watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== ghrd_ctrl.f ====
+incdir+verification
rtl/ghrd_pkg.sv
rtl/panel_if.sv
rtl/button_debouncer.sv
rtl/reset_pulse_stretcher.sv
rtl/heartbeat_blinker.sv
rtl/ghrd_csr.sv
rtl/ghrd_ctrl_top.sv
verification/ghrd_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run of the ghrd_ctrl testbench

TOP       ?= ghrd_ctrl_tb
SEED      ?= 1
VERILATOR ?= verilator
FILELIST  ?= ghrd_ctrl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if TEST OK is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: TOP SEED VERILATOR FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)
